//--- arb_params.svh
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// byte address seen by both caches
`define ARB_ADDR_W    32

// 32-byte lines
`define ARB_OFFSET_W  5
`define ARB_LINE_W    256

// 64 lines in the backing memory
`define MEM_INDEX_W   6

// cycles from first strobe to response
`define MEM_LATENCY   4

`endif

//--- mem_cmd_pkg.sv
`default_nettype none

package mem_cmd_pkg;

    // operation placed on the memory side
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } mem_op_e;

    // which cache port owns the memory
    typedef enum logic {
        src_inst = 1'b0,
        src_data = 1'b1
    } req_src_e;

endpackage : mem_cmd_pkg

`default_nettype wire

//--- arb_state_pkg.sv
`default_nettype none

package arb_state_pkg;

    // st_done covers the two cycles the dropped
    // strobe needs to clear the input buffer
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mem  = 2'd1,
        st_resp = 2'd2,
        st_done = 2'd3
    } arb_state_e;

endpackage : arb_state_pkg

`default_nettype wire

//--- arbiter_control.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter_control import mem_cmd_pkg::*, arb_state_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // buffered cache requests
    input  logic     inst_read_i,
    input  logic     data_read_i,
    input  logic     data_write_i,

    // buffered memory response
    input  logic     mem_resp_i,

    output req_src_e grant_o,
    output mem_op_e  mem_op_o,
    output logic     load_inst_o,
    output logic     load_data_o,
    output logic     inst_resp_o,
    output logic     data_resp_o
);

    arb_state_e state_q;
    arb_state_e state_d;
    req_src_e   last_src_q;     // current grant, also the last port served
    req_src_e   pick;
    mem_op_e    op_q;
    mem_op_e    pick_op;
    logic       done_second_q;
    logic       inst_req;
    logic       data_req;
    logic       in_resp;

    assign inst_req = inst_read_i;
    assign data_req = data_read_i | data_write_i;

    // alternate on a tie, otherwise take whoever asks
    always_comb begin
        if (inst_req && data_req) begin
            pick = (last_src_q == src_inst) ? src_data : src_inst;
        end else if (data_req) begin
            pick = src_data;
        end else begin
            pick = src_inst;
        end
    end

    assign pick_op = (pick == src_data && data_write_i) ? op_write : op_read;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle: begin
                if (inst_req || data_req) begin
                    state_d = st_mem;
                end
            end
            st_mem: begin
                if (mem_resp_i) begin
                    state_d = st_resp;
                end
            end
            st_resp: state_d = st_done;
            st_done: begin
                if (done_second_q) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= st_idle;
            last_src_q    <= src_inst;  // first tie goes to data
            op_q          <= op_none;
            done_second_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            done_second_q <= (state_q == st_done) && !done_second_q;
            if (state_q == st_idle && (inst_req || data_req)) begin
                last_src_q <= pick;
                op_q       <= pick_op;
            end
        end
    end

    // strobe held from issue until the response is handed back
    assign mem_op_o = (state_q == st_mem || state_q == st_resp) ? op_q : op_none;
    assign grant_o  = last_src_q;

    assign in_resp     = (state_q == st_resp);
    assign inst_resp_o = in_resp && (last_src_q == src_inst);
    assign data_resp_o = in_resp && (last_src_q == src_data);

    assign load_inst_o = inst_resp_o;                       // inst port only reads
    assign load_data_o = data_resp_o && (op_q == op_read);

endmodule : arbiter_control

`default_nettype wire

//--- arbiter_datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "arb_params.svh"

module arbiter_datapath import mem_cmd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  req_src_e               grant_i,
    input  mem_op_e                mem_op_i,
    input  logic                   load_inst_i,
    input  logic                   load_data_i,

    input  logic [`ARB_ADDR_W-1:0] inst_addr_i,
    input  logic [`ARB_ADDR_W-1:0] data_addr_i,
    input  logic [`ARB_LINE_W-1:0] data_wdata_i,
    input  logic [`ARB_LINE_W-1:0] mem_rdata_i,

    output logic [`ARB_ADDR_W-1:0] mem_addr_o,
    output logic [`ARB_LINE_W-1:0] mem_wdata_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output logic [`ARB_LINE_W-1:0] inst_rdata_o,
    output logic [`ARB_LINE_W-1:0] data_rdata_o
);

    logic [`ARB_ADDR_W-1:0] sel_addr;

    assign sel_addr = (grant_i == src_inst) ? inst_addr_i : data_addr_i;

    // line aligned
    assign mem_addr_o = {sel_addr[`ARB_ADDR_W-1:`ARB_OFFSET_W], {`ARB_OFFSET_W{1'b0}}};

    assign mem_wdata_o = data_wdata_i;   // only the data port writes

    assign mem_read_o  = (mem_op_i == op_read);
    assign mem_write_o = (mem_op_i == op_write);

    // per-port line registers, hold until the next load
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_rdata_o <= '0;
            data_rdata_o <= '0;
        end else begin
            if (load_inst_i) begin
                inst_rdata_o <= mem_rdata_i;
            end
            if (load_data_i) begin
                data_rdata_o <= mem_rdata_i;
            end
        end
    end

endmodule : arbiter_datapath

`default_nettype wire

//--- arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "arb_params.svh"

module arbiter import mem_cmd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // instruction cache, read only
    input  logic [`ARB_ADDR_W-1:0] inst_addr_i,
    input  logic                   inst_read_i,
    output logic [`ARB_LINE_W-1:0] inst_rdata_o,
    output logic                   inst_resp_o,

    // data cache
    input  logic [`ARB_ADDR_W-1:0] data_addr_i,
    input  logic                   data_read_i,
    input  logic                   data_write_i,
    input  logic [`ARB_LINE_W-1:0] data_wdata_i,
    output logic [`ARB_LINE_W-1:0] data_rdata_o,
    output logic                   data_resp_o,

    // line memory
    input  logic [`ARB_LINE_W-1:0] mem_rdata_i,
    input  logic                   mem_resp_i,
    output logic [`ARB_ADDR_W-1:0] mem_addr_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output logic [`ARB_LINE_W-1:0] mem_wdata_o
);

    logic [`ARB_ADDR_W-1:0] buf_inst_addr;
    logic [`ARB_ADDR_W-1:0] buf_data_addr;
    logic [`ARB_LINE_W-1:0] buf_data_wdata;
    logic [`ARB_LINE_W-1:0] buf_mem_rdata;
    logic                   buf_inst_read;
    logic                   buf_data_read;
    logic                   buf_data_write;
    logic                   buf_mem_resp;

    req_src_e               grant;
    mem_op_e                mem_op;
    logic                   load_inst;
    logic                   load_data;
    logic                   ctl_inst_resp;
    logic                   ctl_data_resp;

    // strobes in, memory response back, responses out
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_inst_read  <= 1'b0;
            buf_data_read  <= 1'b0;
            buf_data_write <= 1'b0;
            buf_mem_resp   <= 1'b0;
            inst_resp_o    <= 1'b0;
            data_resp_o    <= 1'b0;
        end else begin
            buf_inst_read  <= inst_read_i;
            buf_data_read  <= data_read_i;
            buf_data_write <= data_write_i;
            buf_mem_resp   <= mem_resp_i;
            inst_resp_o    <= ctl_inst_resp;
            data_resp_o    <= ctl_data_resp;
        end
    end

    // payload follows its strobe by one cycle
    always_ff @(posedge clk) begin
        buf_inst_addr  <= inst_addr_i;
        buf_data_addr  <= data_addr_i;
        buf_data_wdata <= data_wdata_i;
        buf_mem_rdata  <= mem_rdata_i;
    end

    arbiter_control u_control (
        .clk          (clk),
        .rst          (rst),
        .inst_read_i  (buf_inst_read),
        .data_read_i  (buf_data_read),
        .data_write_i (buf_data_write),
        .mem_resp_i   (buf_mem_resp),
        .grant_o      (grant),
        .mem_op_o     (mem_op),
        .load_inst_o  (load_inst),
        .load_data_o  (load_data),
        .inst_resp_o  (ctl_inst_resp),
        .data_resp_o  (ctl_data_resp)
    );

    arbiter_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .grant_i      (grant),
        .mem_op_i     (mem_op),
        .load_inst_i  (load_inst),
        .load_data_i  (load_data),
        .inst_addr_i  (buf_inst_addr),
        .data_addr_i  (buf_data_addr),
        .data_wdata_i (buf_data_wdata),
        .mem_rdata_i  (buf_mem_rdata),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_read_o   (mem_read_o),
        .mem_write_o  (mem_write_o),
        .inst_rdata_o (inst_rdata_o),
        .data_rdata_o (data_rdata_o)
    );

endmodule : arbiter

`default_nettype wire

//--- line_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "arb_params.svh"

module line_memory (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [`ARB_ADDR_W-1:0] mem_addr_i,
    input  logic                   mem_read_i,
    input  logic                   mem_write_i,
    input  logic [`ARB_LINE_W-1:0] mem_wdata_i,
    output logic [`ARB_LINE_W-1:0] mem_rdata_o,
    output logic                   mem_resp_o
);

    localparam int DEPTH = 1 << `MEM_INDEX_W;
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`ARB_LINE_W-1:0]  mem_array [DEPTH];
    logic [`MEM_INDEX_W-1:0] index;
    logic [CNT_W-1:0]        lat_cnt;
    logic                    wait_drop;   // served, strobe not yet released
    logic                    strobe;
    logic                    fire;

    assign index  = mem_addr_i[`ARB_OFFSET_W +: `MEM_INDEX_W];
    assign strobe = mem_read_i | mem_write_i;

    // last counted cycle, response goes out on the next one
    assign fire = strobe && !wait_drop && (lat_cnt == CNT_W'(`MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            lat_cnt    <= '0;
            wait_drop  <= 1'b0;
            mem_resp_o <= 1'b0;
        end else begin
            mem_resp_o <= fire;
            if (fire) begin
                lat_cnt   <= '0;
                wait_drop <= 1'b1;
            end else if (wait_drop) begin
                if (!strobe) begin
                    wait_drop <= 1'b0;
                end
            end else if (strobe) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && mem_read_i) begin
            mem_rdata_o <= mem_array[index];
        end
        if (fire && mem_write_i) begin
            mem_array[index] <= mem_wdata_i;
        end
    end

endmodule : line_memory

`default_nettype wire

//--- mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "arb_params.svh"

module mem_subsystem (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [`ARB_ADDR_W-1:0] inst_addr_i,
    input  logic                   inst_read_i,
    output logic [`ARB_LINE_W-1:0] inst_rdata_o,
    output logic                   inst_resp_o,

    input  logic [`ARB_ADDR_W-1:0] data_addr_i,
    input  logic                   data_read_i,
    input  logic                   data_write_i,
    input  logic [`ARB_LINE_W-1:0] data_wdata_i,
    output logic [`ARB_LINE_W-1:0] data_rdata_o,
    output logic                   data_resp_o
);

    logic [`ARB_ADDR_W-1:0] mem_addr;
    logic [`ARB_LINE_W-1:0] mem_wdata;
    logic [`ARB_LINE_W-1:0] mem_rdata;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_resp;

    arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .inst_addr_i  (inst_addr_i),
        .inst_read_i  (inst_read_i),
        .inst_rdata_o (inst_rdata_o),
        .inst_resp_o  (inst_resp_o),
        .data_addr_i  (data_addr_i),
        .data_read_i  (data_read_i),
        .data_write_i (data_write_i),
        .data_wdata_i (data_wdata_i),
        .data_rdata_o (data_rdata_o),
        .data_resp_o  (data_resp_o),
        .mem_rdata_i  (mem_rdata),
        .mem_resp_i   (mem_resp),
        .mem_addr_o   (mem_addr),
        .mem_read_o   (mem_read),
        .mem_write_o  (mem_write),
        .mem_wdata_o  (mem_wdata)
    );

    line_memory u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_addr_i  (mem_addr),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .mem_resp_o  (mem_resp)
    );

endmodule : mem_subsystem

`default_nettype wire

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "arb_params.svh"

module tb_mem_subsystem;

    localparam logic [1:0] DOP_NONE  = 2'd0;
    localparam logic [1:0] DOP_READ  = 2'd1;
    localparam logic [1:0] DOP_WRITE = 2'd2;
    localparam logic [1:0] PORT_NONE = 2'd0;
    localparam logic [1:0] PORT_INST = 2'd1;
    localparam logic [1:0] PORT_DATA = 2'd2;
    localparam int DEPTH        = 1 << `MEM_INDEX_W;
    localparam int SOLO_LATENCY = `MEM_LATENCY + 5;  // in, issue, memory, return, resp, out

    typedef struct packed {
        logic                   rst_before;
        logic                   inst_en;
        logic [`ARB_ADDR_W-1:0] inst_addr;
        logic [1:0]             data_op;
        logic [`ARB_ADDR_W-1:0] data_addr;
        logic [`ARB_LINE_W-1:0] wdata;
        logic [1:0]             first;      // port expected to answer first
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [`ARB_ADDR_W-1:0] inst_addr_i;
    logic                   inst_read_i;
    logic [`ARB_LINE_W-1:0] inst_rdata_o;
    logic                   inst_resp_o;
    logic [`ARB_ADDR_W-1:0] data_addr_i;
    logic                   data_read_i;
    logic                   data_write_i;
    logic [`ARB_LINE_W-1:0] data_wdata_i;
    logic [`ARB_LINE_W-1:0] data_rdata_o;
    logic                   data_resp_o;

    row_t                   rows[$];
    logic [`ARB_LINE_W-1:0] ref_mem [DEPTH];
    logic                   ref_written [DEPTH];
    logic [`ARB_LINE_W-1:0] inst_hold;
    logic [`ARB_LINE_W-1:0] data_hold;
    logic                   inst_hold_ok;
    logic                   data_hold_ok;
    logic [1:0]             first_src;
    int                     first_lat;
    int                     cycle = 0;
    int                     cycle_limit = 1000000;
    int                     errors = 0;
    int                     checks = 0;
    int                     inst_pulses = 0;
    int                     data_pulses = 0;

    mem_subsystem u_dut (
        .clk          (clk),
        .rst          (rst),
        .inst_addr_i  (inst_addr_i),
        .inst_read_i  (inst_read_i),
        .inst_rdata_o (inst_rdata_o),
        .inst_resp_o  (inst_resp_o),
        .data_addr_i  (data_addr_i),
        .data_read_i  (data_read_i),
        .data_write_i (data_write_i),
        .data_wdata_i (data_wdata_i),
        .data_rdata_o (data_rdata_o),
        .data_resp_o  (data_resp_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // response pulses seen per port
    always @(negedge clk) begin
        if (!rst) begin
            if (inst_resp_o) begin
                inst_pulses++;
            end
            if (data_resp_o) begin
                data_pulses++;
            end
        end
    end

    task automatic check_value(input string what, input logic [`ARB_LINE_W-1:0] got,
                               input logic [`ARB_LINE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [`ARB_LINE_W-1:0] random_line();
        logic [`ARB_LINE_W-1:0] line;
        for (int w = 0; w < `ARB_LINE_W / 32; w++) begin
            line[w*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    function automatic int line_index(input logic [`ARB_ADDR_W-1:0] addr);
        return int'(addr[`ARB_OFFSET_W +: `MEM_INDEX_W]);
    endfunction

    task automatic add_row(input logic rst_before, input logic inst_en,
                           input logic [`ARB_ADDR_W-1:0] inst_addr, input logic [1:0] data_op,
                           input logic [`ARB_ADDR_W-1:0] data_addr, input logic [1:0] first);
        row_t row;
        row.rst_before = rst_before;
        row.inst_en    = inst_en;
        row.inst_addr  = inst_addr;
        row.data_op    = data_op;
        row.data_addr  = data_addr;
        row.wdata      = (data_op == DOP_WRITE) ? random_line() : '0;
        row.first      = first;
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row(1'b0, 1'b0, 32'h000, DOP_WRITE, 32'h020, PORT_DATA);   // line 1
        add_row(1'b0, 1'b0, 32'h000, DOP_READ,  32'h03c, PORT_DATA);
        add_row(1'b0, 1'b0, 32'h000, DOP_WRITE, 32'h040, PORT_DATA);   // line 2
        add_row(1'b0, 1'b1, 32'h044, DOP_NONE,  32'h000, PORT_INST);
        add_row(1'b0, 1'b0, 32'h000, DOP_WRITE, 32'h060, PORT_DATA);   // line 3
        add_row(1'b0, 1'b1, 32'h020, DOP_READ,  32'h068, PORT_INST);   // data went last
        add_row(1'b0, 1'b1, 32'h060, DOP_WRITE, 32'h080, PORT_INST);
        add_row(1'b1, 1'b1, 32'h084, DOP_READ,  32'h040, PORT_DATA);   // tie right after reset
        add_row(1'b0, 1'b1, 32'h020, DOP_WRITE, 32'h0a0, PORT_DATA);
        add_row(1'b0, 1'b0, 32'h000, DOP_READ,  32'h0bf, PORT_DATA);
        for (int k = 8; k < 16; k++) begin
            add_row(1'b0, 1'b0, 32'h000, DOP_WRITE, 32'(k * 32), PORT_DATA);
        end
        // read back out of order with some contention
        add_row(1'b0, 1'b0, 32'h000, DOP_READ,  32'h1a4, PORT_DATA);
        add_row(1'b0, 1'b1, 32'h13f, DOP_NONE,  32'h000, PORT_INST);
        add_row(1'b0, 1'b1, 32'h1e0, DOP_READ,  32'h108, PORT_DATA);
        add_row(1'b0, 1'b1, 32'h180, DOP_WRITE, 32'h280, PORT_DATA);
        add_row(1'b0, 1'b0, 32'h000, DOP_READ,  32'h140, PORT_DATA);
        add_row(1'b0, 1'b1, 32'h1c0, DOP_READ,  32'h17c, PORT_INST);
        add_row(1'b0, 1'b1, 32'h290, DOP_NONE,  32'h000, PORT_INST);
        add_row(1'b0, 1'b0, 32'h000, DOP_READ,  32'h18c, PORT_DATA);
    endtask

    task automatic do_reset();
        rst          = 1'b1;
        inst_read_i  = 1'b0;
        data_read_i  = 1'b0;
        data_write_i = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst          = 1'b0;
        inst_hold_ok = 1'b0;
        data_hold_ok = 1'b0;
        // nothing asked for yet
        repeat (5) begin
            @(negedge clk);
            check_value("inst_resp_o while idle", 256'(inst_resp_o), '0);
            check_value("data_resp_o while idle", 256'(data_resp_o), '0);
        end
    endtask

    task automatic note_response(input logic [1:0] port, input int lat);
        if (first_src == PORT_NONE) begin
            first_src = port;
            first_lat = lat;
        end
    endtask

    task automatic serve_inst(input logic [`ARB_LINE_W-1:0] exp, input int c0);
        do begin
            @(negedge clk);
        end while (inst_resp_o !== 1'b1);
        check_value("inst_rdata_o on response", inst_rdata_o, exp);
        note_response(PORT_INST, cycle - c0);
        @(posedge clk);
        #1;
        inst_read_i = 1'b0;
    endtask

    task automatic serve_data(input logic [1:0] op, input logic [`ARB_LINE_W-1:0] exp,
                              input int c0);
        do begin
            @(negedge clk);
        end while (data_resp_o !== 1'b1);
        if (op == DOP_READ) begin
            check_value("data_rdata_o on response", data_rdata_o, exp);
        end
        note_response(PORT_DATA, cycle - c0);
        @(posedge clk);
        #1;
        data_read_i  = 1'b0;
        data_write_i = 1'b0;
    endtask

    task automatic apply_row(input int r);
        row_t                   row;
        logic [`ARB_LINE_W-1:0] exp_inst;
        logic [`ARB_LINE_W-1:0] exp_data;
        int                     c0;
        int                     inst_base;
        int                     data_base;
        row = rows[r];
        if (row.rst_before) begin
            #1;
            do_reset();
        end
        exp_inst = ref_mem[line_index(row.inst_addr)];
        exp_data = ref_mem[line_index(row.data_addr)];
        if ((row.inst_en && !ref_written[line_index(row.inst_addr)]) ||
            (row.data_op == DOP_READ && !ref_written[line_index(row.data_addr)])) begin
            errors++;
            $display("table row %0d reads a line that was never written", r);
        end
        first_src = PORT_NONE;
        first_lat = 0;
        inst_base = inst_pulses;
        data_base = data_pulses;
        @(posedge clk);
        #1;
        inst_addr_i  = row.inst_addr;
        inst_read_i  = row.inst_en;
        data_addr_i  = row.data_addr;
        data_wdata_i = row.wdata;
        data_read_i  = (row.data_op == DOP_READ);
        data_write_i = (row.data_op == DOP_WRITE);
        c0 = cycle;
        fork
            begin
                if (row.inst_en) begin
                    serve_inst(exp_inst, c0);
                end
            end
            begin
                if (row.data_op != DOP_NONE) begin
                    serve_data(row.data_op, exp_data, c0);
                end
            end
        join
        repeat (2) @(posedge clk);
        if (row.data_op == DOP_WRITE) begin
            ref_mem[line_index(row.data_addr)]     = row.wdata;
            ref_written[line_index(row.data_addr)] = 1'b1;
            data_hold_ok = 1'b0;    // a write leaves data_rdata_o undefined
        end else if (row.data_op == DOP_READ) begin
            data_hold    = exp_data;
            data_hold_ok = 1'b1;
        end
        if (row.inst_en) begin
            inst_hold    = exp_inst;
            inst_hold_ok = 1'b1;
        end
        check_value("inst response pulses", 256'(inst_pulses - inst_base), 256'(row.inst_en));
        check_value("data response pulses", 256'(data_pulses - data_base),
                    256'(row.data_op != DOP_NONE));
        check_value("port answered first", 256'(first_src), 256'(row.first));
        check_value("first response latency", 256'(first_lat), 256'(SOLO_LATENCY));
        if (inst_hold_ok) begin
            check_value("inst_rdata_o held", inst_rdata_o, inst_hold);
        end
        if (data_hold_ok) begin
            check_value("data_rdata_o held", data_rdata_o, data_hold);
        end
    endtask

    initial begin
        void'($urandom(32'hdcbc55eb));
        rst          = 1'b1;
        inst_addr_i  = '0;
        inst_read_i  = 1'b0;
        data_addr_i  = '0;
        data_read_i  = 1'b0;
        data_write_i = 1'b0;
        data_wdata_i = '0;
        inst_hold    = '0;
        data_hold    = '0;
        inst_hold_ok = 1'b0;
        data_hold_ok = 1'b0;
        first_src    = PORT_NONE;
        first_lat    = 0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_written[i] = 1'b0;
        end
        build_table();
        cycle_limit = 20 * rows.size() + 200;
        do_reset();
        for (int r = 0; r < rows.size(); r++) begin
            apply_row(r);
        end
        $display("%0d errors in %0d checks over %0d rows", errors, checks, rows.size());
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

`default_nettype wire

//--- build.f
+incdir+.
mem_cmd_pkg.sv
arb_state_pkg.sv
arbiter_control.sv
arbiter_datapath.sv
arbiter.sv
line_memory.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_mem_subsystem
FILELIST  = build.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP), fail if the log reports errors"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
